//--- io_pkg.sv
package io_pkg;

	// host bus widths
	localparam int ADDR_W = 2;
	localparam int DATA_W = 16;

	// field widths inside a register word
	localparam int SDC_W   = 4;	// sd data pins
	localparam int PS2_W   = 2;	// ps2 clk in bit 0, data in bit 1
	localparam int SPARE_W = 6;	// unused top bits of pin control
	localparam int DIGIT_W = 4;	// one hex digit

	// register map
	localparam logic [ADDR_W-1:0] REG_PINCTL  = 2'd0;
	localparam logic [ADDR_W-1:0] REG_SEGDATA = 2'd1;
	localparam logic [ADDR_W-1:0] REG_STATUS  = 2'd2;	// read only

	// pin control view of a write word, sdc_out in the low nibble
	typedef struct packed {
		logic [SPARE_W-1:0] spare;	// read back as zero
		logic               ps2_data_low;
		logic               ps2_clk_low;
		logic [SDC_W-1:0]   sdc_oe;
		logic [SDC_W-1:0]   sdc_out;
	} pin_view_t;

	// display view, digit 0 in the low nibble
	typedef struct packed {
		logic [DIGIT_W-1:0] digit3;
		logic [DIGIT_W-1:0] digit2;
		logic [DIGIT_W-1:0] digit1;
		logic [DIGIT_W-1:0] digit0;
	} seg_view_t;

	// one host write word, decoded by address
	typedef union packed {
		pin_view_t pin;
		seg_view_t seg;
	} wr_word_u;

	// REG_STATUS uses the pin_view bit positions for the levels:
	// sd pins in [3:0], ps2 clk level in bit 8, ps2 data level in bit 9

endpackage

//--- seg_scan.sv
module seg_scan import io_pkg::*; #(
	parameter int SCAN_DIV = 16	// cycles each digit stays lit
) (
	input  logic              clock,
	input  logic              rst_n_i,
	input  logic [DATA_W-1:0] seg_digits_i,
	output logic [3:0]        seg_char_o,	// active low digit select
	output logic [7:0]        seg_seg_o	// active low, dp in bit 7
);

	localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

	logic [CNT_W-1:0]   div_q;
	logic [1:0]         idx_q;
	logic [DIGIT_W-1:0] nibble;
	logic [6:0]         seg_on;	// gfedcba, high means lit

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			div_q <= '0;
			idx_q <= '0;
		end else if (div_q == CNT_W'(SCAN_DIV - 1)) begin
			div_q <= '0;
			idx_q <= idx_q + 2'd1;	// wraps 3 back to 0
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	assign nibble = seg_digits_i[idx_q*DIGIT_W +: DIGIT_W];

	// hex table
	always_comb begin
		case (nibble)
			4'h0: seg_on = 7'h3f;
			4'h1: seg_on = 7'h06;
			4'h2: seg_on = 7'h5b;
			4'h3: seg_on = 7'h4f;
			4'h4: seg_on = 7'h66;
			4'h5: seg_on = 7'h6d;
			4'h6: seg_on = 7'h7d;
			4'h7: seg_on = 7'h07;
			4'h8: seg_on = 7'h7f;
			4'h9: seg_on = 7'h6f;
			4'ha: seg_on = 7'h77;
			4'hb: seg_on = 7'h7c;	// lower case b
			4'hc: seg_on = 7'h39;
			4'hd: seg_on = 7'h5e;	// lower case d
			4'he: seg_on = 7'h79;
			default: seg_on = 7'h71;	// F
		endcase
	end

	assign seg_char_o = ~(4'b0001 << idx_q);
	assign seg_seg_o  = {1'b1, ~seg_on};	// decimal point never lit

endmodule

//--- pin_ctrl.sv
module pin_ctrl import io_pkg::*; (
	input  logic             clock,
	input  logic             rst_n_i,

	input  logic [SDC_W-1:0] pin_out_i,
	input  logic [SDC_W-1:0] pin_oe_i,
	input  logic             ps2_clk_low_i,
	input  logic             ps2_data_low_i,

	input  logic [SDC_W-1:0] sdc_in_i,	// raw pad levels, async
	input  logic [PS2_W-1:0] ps2_in_i,

	output logic [SDC_W-1:0] sdc_out_o,
	output logic [SDC_W-1:0] sdc_oe_o,
	output logic [PS2_W-1:0] ps2_low_o,

	output logic [SDC_W-1:0] pin_sync_o,
	output logic [PS2_W-1:0] ps2_sync_o
);

	localparam int IN_W = SDC_W + PS2_W;

	logic [SDC_W-1:0] sdc_out_q;
	logic [SDC_W-1:0] sdc_oe_q;
	logic [PS2_W-1:0] ps2_low_q;

	logic [IN_W-1:0]  pad_in;
	logic [IN_W-1:0]  meta_q;	// first stage, may go metastable
	logic [IN_W-1:0]  sync_q;

	// pads only change on clock edges
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sdc_out_q <= '0;
			sdc_oe_q  <= '0;
			ps2_low_q <= '0;	// both ps2 lines released
		end else begin
			sdc_out_q <= pin_out_i;
			sdc_oe_q  <= pin_oe_i;
			ps2_low_q <= {ps2_data_low_i, ps2_clk_low_i};
		end
	end

	// all six inputs share one two stage synchronizer
	assign pad_in = {ps2_in_i, sdc_in_i};

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
		end else begin
			meta_q <= pad_in;
			sync_q <= meta_q;
		end
	end

	assign sdc_out_o  = sdc_out_q;
	assign sdc_oe_o   = sdc_oe_q;
	assign ps2_low_o  = ps2_low_q;
	assign pin_sync_o = sync_q[SDC_W-1:0];
	assign ps2_sync_o = sync_q[IN_W-1:SDC_W];

endmodule

//--- io_regs.sv
module io_regs import io_pkg::*; (
	input  logic              clock,
	input  logic              rst_n_i,

	input  logic              wr_stb_i,
	input  logic              rd_stb_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              rvalid_o,

	input  logic [SDC_W-1:0]  pin_sync_i,
	input  logic [PS2_W-1:0]  ps2_sync_i,

	output logic [SDC_W-1:0]  pin_out_o,
	output logic [SDC_W-1:0]  pin_oe_o,
	output logic              ps2_clk_low_o,
	output logic              ps2_data_low_o,
	output logic [DATA_W-1:0] seg_digits_o
);

	wr_word_u          wr_word;
	logic              pin_wr;
	logic              seg_wr;

	logic [SDC_W-1:0]  pin_out_q, pin_out_n;
	logic [SDC_W-1:0]  pin_oe_q, pin_oe_n;
	logic              clk_low_q, clk_low_n;
	logic              data_low_q, data_low_n;
	logic [DATA_W-1:0] seg_q;
	logic [DATA_W-1:0] status_q;

	logic [DATA_W-1:0] rd_mux;
	logic [DATA_W-1:0] rdata_q;
	logic              rvalid_q;

	assign wr_word = wdata_i;
	assign pin_wr  = wr_stb_i && (addr_i == REG_PINCTL);
	assign seg_wr  = wr_stb_i && (addr_i == REG_SEGDATA);

	// next pin control, so pin_ctrl picks a write up on the same edge
	always_comb begin
		pin_out_n  = pin_out_q;
		pin_oe_n   = pin_oe_q;
		clk_low_n  = clk_low_q;
		data_low_n = data_low_q;
		if (pin_wr) begin
			pin_out_n  = wr_word.pin.sdc_out;
			pin_oe_n   = wr_word.pin.sdc_oe;
			clk_low_n  = wr_word.pin.ps2_clk_low;
			data_low_n = wr_word.pin.ps2_data_low;	// spare bits dropped here
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pin_out_q  <= '0;
			pin_oe_q   <= '0;
			clk_low_q  <= 1'b0;
			data_low_q <= 1'b0;
			seg_q      <= '0;
			status_q   <= '0;
		end else begin
			pin_out_q  <= pin_out_n;
			pin_oe_q   <= pin_oe_n;
			clk_low_q  <= clk_low_n;
			data_low_q <= data_low_n;
			if (seg_wr)
				seg_q <= {wr_word.seg.digit3, wr_word.seg.digit2,
				          wr_word.seg.digit1, wr_word.seg.digit0};
			// pad levels at the pin_view positions
			status_q <= {{SPARE_W{1'b0}}, ps2_sync_i[1], ps2_sync_i[0],
			             {SDC_W{1'b0}}, pin_sync_i};
		end
	end

	always_comb begin
		case (addr_i)
			REG_PINCTL:  rd_mux = {{SPARE_W{1'b0}}, data_low_q, clk_low_q, pin_oe_q, pin_out_q};
			REG_SEGDATA: rd_mux = seg_q;
			REG_STATUS:  rd_mux = status_q;
			default:     rd_mux = '0;	// address 3 is empty
		endcase
	end

	// read answers one cycle after the strobe
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_q  <= '0;
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= rd_stb_i;
			if (rd_stb_i)
				rdata_q <= rd_mux;
		end
	end

	assign rdata_o        = rdata_q;
	assign rvalid_o       = rvalid_q;
	assign pin_out_o      = pin_out_n;
	assign pin_oe_o       = pin_oe_n;
	assign ps2_clk_low_o  = clk_low_n;
	assign ps2_data_low_o = data_low_n;
	assign seg_digits_o   = seg_q;

endmodule

//--- io_core.sv
module io_core import io_pkg::*; #(
	parameter int SCAN_DIV = 16
) (
	input  logic              clock,
	input  logic              rst_n_i,

	input  logic              wr_stb_i,
	input  logic              rd_stb_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              rvalid_o,

	input  logic [SDC_W-1:0]  sdc_in_i,
	output logic [SDC_W-1:0]  sdc_out_o,
	output logic [SDC_W-1:0]  sdc_oe_o,
	input  logic [PS2_W-1:0]  ps2_in_i,
	output logic [PS2_W-1:0]  ps2_low_o,

	output logic [3:0]        seg_char_o,
	output logic [7:0]        seg_seg_o
);

	logic [SDC_W-1:0]  pin_out;
	logic [SDC_W-1:0]  pin_oe;
	logic              ps2_clk_low;
	logic              ps2_data_low;
	logic [SDC_W-1:0]  pin_sync;
	logic [PS2_W-1:0]  ps2_sync;
	logic [DATA_W-1:0] seg_digits;

	io_regs u_regs (
		.clock          (clock),
		.rst_n_i        (rst_n_i),
		.wr_stb_i       (wr_stb_i),
		.rd_stb_i       (rd_stb_i),
		.addr_i         (addr_i),
		.wdata_i        (wdata_i),
		.rdata_o        (rdata_o),
		.rvalid_o       (rvalid_o),
		.pin_sync_i     (pin_sync),
		.ps2_sync_i     (ps2_sync),
		.pin_out_o      (pin_out),
		.pin_oe_o       (pin_oe),
		.ps2_clk_low_o  (ps2_clk_low),
		.ps2_data_low_o (ps2_data_low),
		.seg_digits_o   (seg_digits)
	);

	pin_ctrl u_pins (
		.clock          (clock),
		.rst_n_i        (rst_n_i),
		.pin_out_i      (pin_out),
		.pin_oe_i       (pin_oe),
		.ps2_clk_low_i  (ps2_clk_low),
		.ps2_data_low_i (ps2_data_low),
		.sdc_in_i       (sdc_in_i),
		.ps2_in_i       (ps2_in_i),
		.sdc_out_o      (sdc_out_o),
		.sdc_oe_o       (sdc_oe_o),
		.ps2_low_o      (ps2_low_o),
		.pin_sync_o     (pin_sync),
		.ps2_sync_o     (ps2_sync)
	);

	seg_scan #(
		.SCAN_DIV     (SCAN_DIV)
	) u_scan (
		.clock        (clock),
		.rst_n_i      (rst_n_i),
		.seg_digits_i (seg_digits),
		.seg_char_o   (seg_char_o),
		.seg_seg_o    (seg_seg_o)
	);

endmodule

//--- pad_ring.sv
module pad_ring import io_pkg::*; #(
	parameter int SCAN_DIV = 16	// cycles per lit digit
) (
	input  logic              clock,
	input  logic              rst_n_i,

	input  logic              wr_stb_i,
	input  logic              rd_stb_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              rvalid_o,

	inout  wire  [SDC_W-1:0]  sdc_dat_io,
	inout  wire               ps2_clk_io,
	inout  wire               ps2_data_io,

	output logic [3:0]        seg_char_o,
	output logic [7:0]        seg_seg_o
);

	logic [SDC_W-1:0] sdc_in;
	logic [SDC_W-1:0] sdc_out;
	logic [SDC_W-1:0] sdc_oe;
	logic [PS2_W-1:0] ps2_in;
	logic [PS2_W-1:0] ps2_low;

	// sd data pads are plain tristate, one enable per bit
	for (genvar i = 0; i < SDC_W; i++) begin : g_sdc_pad
		assign sdc_dat_io[i] = sdc_oe[i] ? sdc_out[i] : 1'bz;
	end
	assign sdc_in = sdc_dat_io;

	// ps2 lines are open drain, only ever pulled low
	assign ps2_clk_io  = ps2_low[0] ? 1'b0 : 1'bz;
	assign ps2_data_io = ps2_low[1] ? 1'b0 : 1'bz;
	assign ps2_in      = {ps2_data_io, ps2_clk_io};	// board pullups give high when idle

	io_core #(
		.SCAN_DIV   (SCAN_DIV)
	) u_core (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.wr_stb_i   (wr_stb_i),
		.rd_stb_i   (rd_stb_i),
		.addr_i     (addr_i),
		.wdata_i    (wdata_i),
		.rdata_o    (rdata_o),
		.rvalid_o   (rvalid_o),
		.sdc_in_i   (sdc_in),
		.sdc_out_o  (sdc_out),
		.sdc_oe_o   (sdc_oe),
		.ps2_in_i   (ps2_in),
		.ps2_low_o  (ps2_low),
		.seg_char_o (seg_char_o),
		.seg_seg_o  (seg_seg_o)
	);

endmodule

//--- io_props.sv
module io_props import io_pkg::*; (
	input logic             clock,
	input logic             rst_n_i,
	input logic             rd_stb_i,
	input logic             rvalid_i,
	input logic [3:0]       seg_char_i,
	input logic [PS2_W-1:0] ps2_low_i,
	input logic [SDC_W-1:0] sdc_oe_i
);

	int fail_count = 0;	// failed assertions so far

	// read answers exactly one cycle after its strobe
	rvalid_follows_strobe: assert property (@(posedge clock) disable iff (!rst_n_i)
		rvalid_i == $past(rd_stb_i))
		else begin
			$error("rvalid does not follow the read strobe of the previous cycle");
			fail_count++;
		end

	// one digit selected and stepping in order 0 to 3
	digit_select_one_hot: assert property (@(posedge clock) disable iff (!rst_n_i)
		$onehot(~seg_char_i) && (seg_char_i == $past(seg_char_i) ||
			seg_char_i == {$past(seg_char_i[2:0]), $past(seg_char_i[3])}))
		else begin
			$error("seg_char is not one-hot-low or skipped a digit");
			fail_count++;
		end

	// no pad driven while reset is held
	pads_quiet_in_reset: assert property (@(posedge clock)
		!rst_n_i |-> (ps2_low_i == '0 && sdc_oe_i == '0))
		else begin
			$error("pad enable or ps2 pull active during reset");
			fail_count++;
		end

endmodule

bind io_core io_props u_props (
	.clock      (clock),
	.rst_n_i    (rst_n_i),
	.rd_stb_i   (rd_stb_i),
	.rvalid_i   (rvalid_o),
	.seg_char_i (seg_char_o),
	.ps2_low_i  (ps2_low_o),
	.sdc_oe_i   (sdc_oe_o)
);

//--- tb_pad_ring.sv
module tb_pad_ring import io_pkg::*;;

	localparam int SCAN_DIV  = 16;
	localparam int CLK_HALF  = 50;
	localparam int DRV_DLY   = 5;	// inputs change this long after the rising edge
	localparam int MAX_CASES = 64;
	localparam int NAME_W    = 8 * 24;

	// lit segments in gfedcba order
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	logic              clock = 1'b0;
	logic              rst_n;
	logic              wr_stb;
	logic              rd_stb;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              rvalid;
	logic [3:0]        seg_char;
	logic [7:0]        seg_seg;

	tri1 [SDC_W-1:0]   sdc_pad;
	tri1               ps2_clk;
	tri1               ps2_data;

	logic [SDC_W-1:0]  drv_en;	// testbench side of the sd pads
	logic [SDC_W-1:0]  drv_lvl;
	logic              drv_clk_low;
	logic              drv_data_low;

	logic [NAME_W-1:0] c_name [MAX_CASES];
	logic [7:0]        c_op   [MAX_CASES];
	logic [15:0]       c_addr [MAX_CASES];
	logic [15:0]       c_val  [MAX_CASES];
	logic [15:0]       c_exp  [MAX_CASES];
	int                n_cases = 0;

	for (genvar i = 0; i < SDC_W; i++) begin : g_drv
		assign sdc_pad[i] = drv_en[i] ? drv_lvl[i] : 1'bz;
	end
	assign ps2_clk  = drv_clk_low  ? 1'b0 : 1'bz;
	assign ps2_data = drv_data_low ? 1'b0 : 1'bz;

	pad_ring #(
		.SCAN_DIV    (SCAN_DIV)
	) u_dut (
		.clock       (clock),
		.rst_n_i     (rst_n),
		.wr_stb_i    (wr_stb),
		.rd_stb_i    (rd_stb),
		.addr_i      (addr),
		.wdata_i     (wdata),
		.rdata_o     (rdata),
		.rvalid_o    (rvalid),
		.sdc_dat_io  (sdc_pad),
		.ps2_clk_io  (ps2_clk),
		.ps2_data_io (ps2_data),
		.seg_char_o  (seg_char),
		.seg_seg_o   (seg_seg)
	);

	always #CLK_HALF clock = ~clock;

	task automatic abort_run(input string msg);
		$display("ERROR: %s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_val(input logic [NAME_W-1:0] name, input logic [15:0] exp,
			input logic [15:0] act);
		if (exp !== act) begin
			$display("MISMATCH %0s: expected %h, actual %h", name, exp, act);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic next_cycle;
		@(posedge clock);
		#DRV_DLY;
	endtask

	task automatic load_cases;
		int                fd;
		int                r;
		logic [NAME_W-1:0] tok;
		logic [7:0]        op;
		logic [15:0]       a, v, e;
		logic [8*128-1:0]  rest;
		fd = $fopen("io_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open io_cases.txt");
		while (!$feof(fd)) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1)
				break;
			if (tok[7:0] == "#" && tok[NAME_W-1:8] == '0) begin
				r = $fgets(rest, fd);	// skip comment line
			end else begin
				r = $fscanf(fd, "%s %h %h %h", op, a, v, e);
				if (r != 4 || n_cases >= MAX_CASES)
					abort_run($sformatf("bad or surplus case line %0s", tok));
				c_name[n_cases] = tok;
				c_op[n_cases]   = op;
				c_addr[n_cases] = a;
				c_val[n_cases]  = v;
				c_exp[n_cases]  = e;
				n_cases++;
			end
		end
		$fclose(fd);
		if (n_cases == 0)
			abort_run("no cases found in io_cases.txt");
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
		addr   = a;
		wdata  = d;
		wr_stb = 1'b1;
		next_cycle();
		wr_stb = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
		int n;
		addr   = a;
		rd_stb = 1'b1;
		next_cycle();
		rd_stb = 1'b0;
		n = 0;
		while (!rvalid) begin
			if (n >= 4)
				abort_run($sformatf("read of address %0d got no rvalid", a));
			next_cycle();
			n++;
		end
		d = rdata;
	endtask

	// levels in [3:0] and enables in [7:4] with the ps2 pulls in bits 8 and 9
	task automatic drive_pads(input logic [15:0] v);
		drv_lvl      = v[3:0];
		drv_en       = v[7:4];
		drv_clk_low  = v[8];
		drv_data_low = v[9];
	endtask

	function automatic logic [15:0] pad_word();
		return {6'b0, ps2_data, ps2_clk, 4'b0, sdc_pad};	// same layout as status
	endfunction

	task automatic check_scan(input logic [NAME_W-1:0] name, input logic [15:0] digits);
		logic [3:0] prev;
		logic [3:0] sel;
		logic [3:0] nib;
		int         n;
		int         lit;
		n    = 0;
		prev = seg_char;
		next_cycle();
		// wait for digit 0 to take over
		while (!(seg_char == 4'b1110 && prev != 4'b1110)) begin
			if (n > 5 * SCAN_DIV)
				abort_run("display never stepped back to digit 0");
			prev = seg_char;
			next_cycle();
			n++;
		end
		for (int d = 0; d < 4; d++) begin
			sel    = 4'b1111;
			sel[d] = 1'b0;
			nib    = digits[d*4 +: 4];
			check_val(name, {12'h0, sel}, {12'h0, seg_char});
			check_val(name, {8'h0, 1'b1, ~SEG_TABLE[nib]}, {8'h0, seg_seg});
			lit = 1;
			next_cycle();
			while (seg_char == sel) begin
				if (lit > 2 * SCAN_DIV)
					abort_run($sformatf("digit %0d stays lit too long", d));
				lit++;
				next_cycle();
			end
			check_val(name, 16'(SCAN_DIV), 16'(lit));	// dwell time per digit
		end
	endtask

	task automatic run_case(input int i);
		logic [DATA_W-1:0] rd;
		case (c_op[i])
			"W": write_reg(c_addr[i][ADDR_W-1:0], c_val[i]);
			"R": begin
				read_reg(c_addr[i][ADDR_W-1:0], rd);
				check_val(c_name[i], c_exp[i], rd);
			end
			"D": begin
				drive_pads(c_val[i]);
				repeat (4) next_cycle();	// past the synchronizer and status stage
				check_val(c_name[i], c_exp[i], pad_word());
			end
			"S": check_scan(c_name[i], c_exp[i]);
			default: abort_run($sformatf("unknown opcode in case %0s", c_name[i]));
		endcase
	endtask

	// watchdog budget scales with the case count
	initial begin
		wait (n_cases > 0);
		repeat (n_cases * 8 * SCAN_DIV + 200) @(posedge clock);
		abort_run("watchdog timeout, the run did not finish in time");
	end

	// a failed bound assertion ends the run on the next edge
	always @(posedge clock) begin
		if (u_dut.u_core.u_props.fail_count != 0)
			abort_run("a bound assertion failed");
	end

	initial begin
		rst_n  = 1'b1;
		wr_stb = 1'b0;
		rd_stb = 1'b0;
		addr   = '0;
		wdata  = '0;
		drive_pads(16'h0000);
		load_cases();
		#1 rst_n = 1'b0;
		repeat (8) @(posedge clock);
		#DRV_DLY rst_n = 1'b1;
		next_cycle();
		for (int i = 0; i < n_cases; i++)
			run_case(i);
		if (u_dut.u_core.u_props.fail_count != 0) begin
			$display("ERROR: %0d assertion failures", u_dut.u_core.u_props.fail_count);
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

//--- io_cases.txt
# name op addr value expected, all hex; W write, R read, D drive pads, S check display
# D value: [3:0] levels, [7:4] enables, [8] clk low, [9] data low; expected is pad levels
rst_pinctl    R 0 0000 0000
rst_segdata   R 1 0000 0000
rst_status    R 2 0000 030f
rst_pads      D 0 0000 030f
pinctl_wr     W 0 fc31 0000
pinctl_rd     R 0 0000 0031
oe_pads       D 0 0000 030d
sd_drive      D 0 00c4 0305
sd_status     R 2 0000 0305
clk_pull_wr   W 0 0131 0000
clk_pull_pad  D 0 00c4 0205
clk_pull_st   R 2 0000 0205
clk_rel_wr    W 0 0031 0000
clk_rel_pad   D 0 00c4 0305
data_ext_pad  D 0 02c4 0105
data_ext_st   R 2 0000 0105
data_ext_reg  R 0 0000 0031
release_pad   D 0 0000 030d
release_st    R 2 0000 030d
status_wr     W 2 ffff 0000
status_rd     R 2 0000 030d
addr3_wr      W 3 ffff 0000
addr3_rd      R 3 0000 0000
seg_wr        W 1 3a7c 0000
seg_rd        R 1 0000 3a7c
seg_scan      S 1 0000 3a7c
seg_wr2       W 1 b0e5 0000
seg_scan2     S 1 0000 b0e5

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pad_ring
FLAGS     ?= --timing --assert
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f

.PHONY: build run clean

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
io_pkg.sv
seg_scan.sv
pin_ctrl.sv
io_regs.sv
io_core.sv
pad_ring.sv
io_props.sv
tb_pad_ring.sv
